/* video_status_buffer.f */
+incdir+include
hdl/vsb_pkg.sv
hdl/vsb_status_if.sv
hdl/sync_bus.sv
hdl/status_capture.sv
hdl/status_wr_arbiter.sv
hdl/status_fifo.sv
hdl/video_status_buffer.sv
verif/vsb_checker.sv
verif/vsb_asserts.sv
verif/tb_video_status_buffer.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := tb_video_status_buffer
FILELIST  := video_status_buffer.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* verif/tb_video_status_buffer.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module tb_video_status_buffer;

    localparam int NUM_CH = `VSB_NUM_CH;

    typedef struct packed {
        logic [1:0]             ch;         // NUM_CH means both channels
        logic [`VSB_DT_W-1:0]   dt;
        logic [`VSB_ID_W-1:0]   wc;
        logic [`VSB_LC_W-1:0]   lc;
        logic [7:0]             hlen;       // Cycles header_en high
        logic [7:0]             gap;        // Cycles low afterwards
        logic                   rd_stop;    // Host reads off
        logic                   drop;       // Record expected to be lost
    } row_t;

    // ======================================================================
    // DUT signals
    // ======================================================================
    logic                               fifo_wrclk = 1'b0;
    logic                               aggre_clk = 1'b0;
    logic                               fifo_wrclk_rst_n = 1'b0;
    logic                               aggre_clk_rst_n = 1'b0;
    logic [`VSB_TS_W-1:0]               local_us_cnt = '0;
    logic [NUM_CH-1:0]                  idi_header_en = '0;
    logic [NUM_CH*`VSB_DT_W-1:0]        idi_datatype = '0;
    logic [NUM_CH*`VSB_ID_W-1:0]        idi_wordcount = '0;
    logic [NUM_CH*`VSB_LC_W-1:0]        idi_linecount = '0;
    logic                               rd_en = 1'b0;
    logic [`VSB_REC_W-1:0]              rd_data;
    logic                               empty;
    logic                               full;
    logic [NUM_CH-1:0]                  overflow;

    logic [NUM_CH-1:0]                  hdr_drop = '0;
    logic                               settled = 1'b0;
    logic                               read_on = 1'b1;
    logic [31:0]                        rng = 32'd81859;
    row_t                               rows [$];
    int                                 cycles = 0;
    int                                 limit = 0;
    int                                 err_cnt;
    int                                 chk_cnt;
    int                                 outstanding;

    video_status_buffer dut (.*);

    vsb_checker u_checker (.*);

    always #2 fifo_wrclk = ~fifo_wrclk;
    always #3 aggre_clk  = ~aggre_clk;

    always @(posedge aggre_clk)
        local_us_cnt <= local_us_cnt + `VSB_TS_W'(1);

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Host read strobe with random gaps
    always @(posedge fifo_wrclk) begin
        logic go;
        go = read_on;
        #1;
        rng   = next_rand(rng);
        rd_en = go & (rng[1:0] != 2'b00);
    end

    always @(posedge fifo_wrclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run not finished after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    task automatic add_row(input int ch, input logic [`VSB_DT_W-1:0] dt,
                           input logic [`VSB_ID_W-1:0] wc, input logic [`VSB_LC_W-1:0] lc,
                           input int hlen, input int gap, input bit rd_stop, input bit drop);
        row_t r;
        rng       = next_rand(rng);
        r.ch      = 2'(ch);
        r.dt      = dt;
        r.wc      = (wc != '0) ? wc : rng[15:0];    // Zero means random
        r.lc      = lc;
        r.hlen    = 8'(hlen);
        r.gap     = 8'(gap);
        r.rd_stop = rd_stop;
        r.drop    = drop;
        rows.push_back(r);
        limit += (hlen + gap) * 4;
    endtask

    task automatic drive_row(input row_t r);
        hdr_drop = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            if (int'(r.ch) == c || int'(r.ch) == NUM_CH) begin
                idi_header_en[c]                           = 1'b1;
                idi_datatype[c*`VSB_DT_W +: `VSB_DT_W]     = r.dt;
                idi_wordcount[c*`VSB_ID_W +: `VSB_ID_W]    = r.wc;
                idi_linecount[c*`VSB_LC_W +: `VSB_LC_W]    = r.lc;
                hdr_drop[c]                                = r.drop;
            end
        end
        repeat (int'(r.hlen)) @(posedge fifo_wrclk);
        #1 idi_header_en = '0;
        repeat (int'(r.gap)) @(posedge fifo_wrclk);
        #1;
    endtask

    // Empty for several cycles in a row, pending records included
    task automatic wait_drained();
        int quiet;
        quiet = 0;
        while (quiet < 6) begin
            @(posedge fifo_wrclk);
            quiet = empty ? quiet + 1 : 0;
        end
        #1;
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        add_row(0, 6'h2C, '0, 3'd5, 3, 4, 0, 0);
        add_row(1, 6'h2D, '0, 3'd7, 2, 4, 0, 0);
        add_row(0, 6'h00, '0, 3'd2, 4, 3, 0, 0);
        add_row(1, 6'h01, 16'h1234, 3'd6, 3, 3, 0, 0);
        add_row(2, 6'h2C, '0, 3'd1, 3, 5, 0, 0);        // Both channels together
        add_row(2, 6'h01, '0, 3'd4, 2, 5, 0, 0);
        add_row(0, 6'h2D, '0, 3'd0, 1, 3, 0, 0);
        add_row(1, 6'h12, '0, 3'd3, 2, 3, 0, 0);
        add_row(2, 6'h00, '0, 3'd7, 3, 6, 0, 0);
        add_row(0, 6'h2C, '0, 3'd6, 2, 10, 0, 0);
        // Reads stopped, fill the FIFO
        for (int i = 0; i < `VSB_FIFO_DEPTH; i++)
            add_row(0, (i % 2 != 0) ? 6'h2C : 6'h01, '0, 3'(i), 2, 4, 1, 0);
        add_row(0, 6'h2D, '0, 3'd5, 2, 4, 1, 0);        // Held pending
        add_row(0, 6'h00, '0, 3'd1, 2, 4, 1, 1);        // Lost
        add_row(0, 6'h2C, '0, 3'd2, 2, 4, 1, 1);
        add_row(1, 6'h01, '0, 3'd0, 2, 6, 1, 0);        // Pending on the other channel
        limit += 200;

        repeat (10) @(posedge fifo_wrclk);
        #1;
        fifo_wrclk_rst_n = 1'b1;
        aggre_clk_rst_n  = 1'b1;
        repeat (4) @(posedge fifo_wrclk);
        #1;

        foreach (rows[i]) begin
            if (rows[i].rd_stop && read_on)
                wait_drained();
            read_on = !rows[i].rd_stop;
            drive_row(rows[i]);
        end

        repeat (4) @(posedge fifo_wrclk);
        #1 settled = 1'b1;
        @(posedge fifo_wrclk);
        #1 settled = 1'b0;
        read_on = 1'b1;
        wait_drained();

        if (outstanding != 0)
            $display("Records never read: %0d", outstanding);
        $display("Checks: %0d  Errors: %0d  Unread: %0d", chk_cnt, err_cnt, outstanding);
        if (err_cnt == 0 && outstanding == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* verif/vsb_asserts.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module vsb_asserts (
    input  logic                        fifo_wrclk,
    input  logic                        fifo_wrclk_rst_n,
    input  logic                        wr_en,
    input  logic                        full,
    input  logic [`VSB_NUM_CH-1:0]      gnt,
    input  logic [`VSB_NUM_CH-1:0]      overflow
);

    // Arbiter must respect back-pressure
    a_no_wr_full: assert property (@(posedge fifo_wrclk) disable iff (!fifo_wrclk_rst_n)
        !(wr_en && full))
        else $error("write while FIFO full");

    a_gnt_onehot: assert property (@(posedge fifo_wrclk) disable iff (!fifo_wrclk_rst_n)
        $onehot0(gnt))
        else $error("more than one grant");

    // Sticky until reset
    a_ovf_sticky: assert property (@(posedge fifo_wrclk) disable iff (!fifo_wrclk_rst_n)
        ($past(overflow) & ~overflow) == '0)
        else $error("overflow fell outside reset");

endmodule

bind video_status_buffer vsb_asserts u_asserts (
    .fifo_wrclk         (fifo_wrclk),
    .fifo_wrclk_rst_n   (fifo_wrclk_rst_n),
    .wr_en              (fifo_wr_en),
    .full               (full),
    .gnt                (u_arbiter.gnt_v),
    .overflow           (overflow)
);

/* verif/vsb_checker.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module vsb_checker (
    input  logic                                fifo_wrclk,
    input  logic                                fifo_wrclk_rst_n,
    input  logic [`VSB_TS_W-1:0]                local_us_cnt,
    input  logic [`VSB_NUM_CH-1:0]              idi_header_en,
    input  logic [`VSB_NUM_CH*`VSB_DT_W-1:0]    idi_datatype,
    input  logic [`VSB_NUM_CH*`VSB_ID_W-1:0]    idi_wordcount,
    input  logic [`VSB_NUM_CH*`VSB_LC_W-1:0]    idi_linecount,
    input  logic [`VSB_NUM_CH-1:0]              hdr_drop,       // Header expected to be lost
    input  logic                                settled,        // Quiet point, levels checked
    input  logic                                rd_en,
    input  logic [`VSB_REC_W-1:0]               rd_data,
    input  logic                                empty,
    input  logic                                full,
    input  logic [`VSB_NUM_CH-1:0]              overflow,
    output int                                  err_cnt,
    output int                                  chk_cnt,
    output int                                  outstanding     // Records expected, not yet read
);

    localparam int NUM_CH = `VSB_NUM_CH;
    localparam int EXP_W  = `VSB_DT_W + `VSB_ID_W;

    // ======================================================================
    // Prediction state
    // ======================================================================
    logic [EXP_W-1:0]           exp_q [NUM_CH][$];  // Datatype and packet id, header order
    logic [NUM_CH-1:0]          hen_d = '0;
    logic [NUM_CH-1:0]          exp_ovf = '0;
    logic [`VSB_DT_W-1:0]       cap_dt [NUM_CH];
    logic [`VSB_ID_W-1:0]       cap_id [NUM_CH];
    logic [`VSB_TS_W-1:0]       last_ts [NUM_CH];
    int                         n_err = 0;
    int                         n_chk = 0;
    int                         n_out = 0;
    int                         rst_cyc = 0;

    assign err_cnt     = n_err;
    assign chk_cnt     = n_chk;
    assign outstanding = n_out;

    // Long packets use the linecount, all others the wordcount
    function automatic logic [`VSB_ID_W-1:0] predict_id(input logic [`VSB_DT_W-1:0] dt,
                                                        input logic [`VSB_ID_W-1:0] wc,
                                                        input logic [`VSB_LC_W-1:0] lc);
        if (dt == 6'h2C || dt == 6'h2D)
            return `VSB_ID_W'(lc);
        return wc;
    endfunction

    task automatic flag_error(input string msg);
        n_err++;
        $display("** Error @%0t: %s", $time, msg);
    endtask

    // ======================================================================
    // Per-cycle compare
    // ======================================================================
    always @(posedge fifo_wrclk) begin
        vsb_pkg::status_rec_t   rec;
        logic [EXP_W-1:0]       exp;
        int                     c;
        if (!fifo_wrclk_rst_n) begin
            rst_cyc++;
            hen_d   = '0;
            exp_ovf = '0;
            for (int k = 0; k < NUM_CH; k++)
                last_ts[k] = '0;
            if (rst_cyc > 2) begin                  // Async reset has settled
                n_chk++;
                if (empty !== 1'b1 || full !== 1'b0 || overflow !== '0)
                    flag_error("outputs not at reset values");
            end
        end else begin
            n_chk++;
            if (overflow !== exp_ovf)
                flag_error($sformatf("overflow %b, expected %b", overflow, exp_ovf));
            if (full === 1'b1 && n_out < `VSB_FIFO_DEPTH)
                flag_error($sformatf("full with only %0d records issued", n_out));
            for (int k = 0; k < NUM_CH; k++) begin
                if (idi_header_en[k] && !hen_d[k]) begin        // Header start
                    cap_dt[k] = idi_datatype[k*`VSB_DT_W +: `VSB_DT_W];
                    cap_id[k] = predict_id(cap_dt[k],
                                           idi_wordcount[k*`VSB_ID_W +: `VSB_ID_W],
                                           idi_linecount[k*`VSB_LC_W +: `VSB_LC_W]);
                end
                if (!idi_header_en[k] && hen_d[k]) begin        // Header end
                    if (hdr_drop[k])
                        exp_ovf[k] = 1'b1;
                    else begin
                        exp_q[k].push_back({cap_dt[k], cap_id[k]});
                        n_out++;
                    end
                end
            end
            hen_d = idi_header_en;
            if (settled) begin
                n_chk++;
                if (full !== (n_out >= `VSB_FIFO_DEPTH) || empty !== (n_out == 0))
                    flag_error($sformatf("full %b empty %b with %0d records held",
                                         full, empty, n_out));
            end
            if (rd_en && !empty) begin
                rec = vsb_pkg::status_rec_t'(rd_data);
                c   = int'(rec.ch);
                n_out--;
                n_chk++;
                if (exp_q[c].size() == 0)
                    flag_error($sformatf("record from channel %0d, none expected", c));
                else begin
                    exp = exp_q[c].pop_front();
                    if ({rec.datatype, rec.pkt_id} !== exp)
                        flag_error($sformatf("ch %0d got dt %h id %h, expected %h",
                                             c, rec.datatype, rec.pkt_id, exp));
                    if (rec.timestamp > local_us_cnt)
                        flag_error($sformatf("ch %0d timestamp %0d ahead of counter", c,
                                             rec.timestamp));
                    if (rec.timestamp < last_ts[c])
                        flag_error($sformatf("ch %0d timestamp went back", c));
                    last_ts[c] = rec.timestamp;
                end
            end
        end
    end

endmodule

/* hdl/video_status_buffer.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module video_status_buffer (
    input  logic                                fifo_wrclk,
    input  logic                                fifo_wrclk_rst_n,
    input  logic                                aggre_clk,
    input  logic                                aggre_clk_rst_n,
    input  logic [`VSB_TS_W-1:0]                local_us_cnt,       // aggre_clk domain
    input  logic [`VSB_NUM_CH-1:0]              idi_header_en,
    input  logic [`VSB_NUM_CH*`VSB_DT_W-1:0]    idi_datatype,       // Channel 0 in low bits
    input  logic [`VSB_NUM_CH*`VSB_ID_W-1:0]    idi_wordcount,
    input  logic [`VSB_NUM_CH*`VSB_LC_W-1:0]    idi_linecount,
    input  logic                                rd_en,
    output logic [`VSB_REC_W-1:0]               rd_data,
    output logic                                empty,
    output logic                                full,
    output logic [`VSB_NUM_CH-1:0]              overflow
);

    // ======================================================================
    // Timestamp crossing from aggre_clk
    // ======================================================================
    vsb_pkg::timestamp_t    us_counter_sync;

    sync_bus #(
        .BUS_WIDTH  (`VSB_TS_W),
        .INI_VALUE  ('0)
    ) u_sync_us_cnt (
        .src_clk    (aggre_clk),
        .src_rst_n  (aggre_clk_rst_n),
        .src_bus    (local_us_cnt),
        .dst_clk    (fifo_wrclk),
        .dst_rst_n  (fifo_wrclk_rst_n),
        .dst_bus    (us_counter_sync)
    );

    // ======================================================================
    // Per-channel capture
    // ======================================================================
    vsb_status_if           stat_if [`VSB_NUM_CH] ();

    for (genvar g = 0; g < `VSB_NUM_CH; g++) begin : g_cap
        status_capture u_capture (
            .fifo_wrclk         (fifo_wrclk),
            .fifo_wrclk_rst_n   (fifo_wrclk_rst_n),
            .idi_header_en      (idi_header_en[g]),
            .idi_datatype       (idi_datatype[g*`VSB_DT_W +: `VSB_DT_W]),
            .idi_wordcount      (idi_wordcount[g*`VSB_ID_W +: `VSB_ID_W]),
            .idi_linecount      (idi_linecount[g*`VSB_LC_W +: `VSB_LC_W]),
            .us_counter_sync    (us_counter_sync),
            .stat               (stat_if[g]),
            .overflow           (overflow[g])
        );
    end

    // ======================================================================
    // Arbiter and status FIFO
    // ======================================================================
    logic                   fifo_wr_en;
    vsb_pkg::status_rec_t   fifo_wr_data;
    vsb_pkg::status_rec_t   fifo_rd_data;

    status_wr_arbiter u_arbiter (
        .fifo_wrclk         (fifo_wrclk),
        .fifo_wrclk_rst_n   (fifo_wrclk_rst_n),
        .stat               (stat_if),
        .fifo_full          (full),
        .wr_en              (fifo_wr_en),
        .wr_data            (fifo_wr_data)
    );

    status_fifo u_fifo (
        .fifo_wrclk         (fifo_wrclk),
        .fifo_wrclk_rst_n   (fifo_wrclk_rst_n),
        .wr_en              (fifo_wr_en),
        .wr_data            (fifo_wr_data),
        .rd_en              (rd_en),
        .rd_data            (fifo_rd_data),
        .full               (full),
        .empty              (empty)
    );

    assign rd_data = fifo_rd_data;          // Flat record for the host

endmodule

/* hdl/status_fifo.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module status_fifo (
    input  logic                    fifo_wrclk,
    input  logic                    fifo_wrclk_rst_n,
    input  logic                    wr_en,
    input  vsb_pkg::status_rec_t    wr_data,
    input  logic                    rd_en,
    output vsb_pkg::status_rec_t    rd_data,
    output logic                    full,
    output logic                    empty
);

    localparam int DEPTH = `VSB_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    // ======================================================================
    // Storage and pointers
    // ======================================================================
    vsb_pkg::status_rec_t   mem [DEPTH];
    logic [AW:0]            wr_ptr;         // Extra bit tells wrap
    logic [AW:0]            rd_ptr;
    logic                   do_wr;
    logic                   do_rd;

    // Same address, wrap bits differ
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign do_wr = wr_en & ~full;           // Write into a full FIFO dropped
    assign do_rd = rd_en & ~empty;          // Read while empty ignored

    always_ff @(posedge fifo_wrclk or negedge fifo_wrclk_rst_n) begin
        if (!fifo_wrclk_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge fifo_wrclk) begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= wr_data;
    end

    // ======================================================================
    // Read side
    // ======================================================================
    // Head entry shown while not empty
    assign rd_data = mem[rd_ptr[AW-1:0]];

endmodule

/* hdl/status_wr_arbiter.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module status_wr_arbiter (
    input  logic                    fifo_wrclk,
    input  logic                    fifo_wrclk_rst_n,
    vsb_status_if.arbiter           stat [`VSB_NUM_CH],
    input  logic                    fifo_full,
    output logic                    wr_en,
    output vsb_pkg::status_rec_t    wr_data
);

    localparam int NUM_CH = `VSB_NUM_CH;

    // ======================================================================
    // Per-channel views of the interfaces
    // ======================================================================
    logic [NUM_CH-1:0]      pend_v;
    logic [NUM_CH-1:0]      gnt_v;
    vsb_pkg::datatype_t     dt_v [NUM_CH];
    vsb_pkg::pkt_id_t       id_v [NUM_CH];
    vsb_pkg::timestamp_t    ts_v [NUM_CH];

    for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
        assign pend_v[g]   = stat[g].pend;
        assign dt_v[g]     = stat[g].datatype;
        assign id_v[g]     = stat[g].pkt_id;
        assign ts_v[g]     = stat[g].timestamp;
        assign stat[g].gnt = gnt_v[g];
    end

    // ======================================================================
    // Round-robin grant
    // ======================================================================
    vsb_pkg::ch_id_t        last_gnt;       // Last channel written
    vsb_pkg::ch_id_t        sel;            // Channel granted this cycle

    always_comb begin
        int idx;
        gnt_v = '0;
        sel   = last_gnt;
        wr_en = 1'b0;
        // Search starts just past the last winner
        for (int k = 1; k <= NUM_CH; k++) begin
            idx = (int'(last_gnt) + k) % NUM_CH;
            if (!wr_en && pend_v[idx] && !fifo_full) begin
                wr_en      = 1'b1;
                gnt_v[idx] = 1'b1;
                sel        = vsb_pkg::ch_id_t'(idx);
            end
        end
    end

    always_ff @(posedge fifo_wrclk or negedge fifo_wrclk_rst_n) begin
        if (!fifo_wrclk_rst_n)
            last_gnt <= vsb_pkg::ch_id_t'(NUM_CH - 1);   // Channel 0 first
        else if (wr_en)
            last_gnt <= sel;
    end

    // Granted record with its channel on top
    assign wr_data = '{ch: sel, datatype: dt_v[sel], pkt_id: id_v[sel], timestamp: ts_v[sel]};

endmodule

/* hdl/status_capture.sv */
`timescale 1ns/10ps
`include "vsb_defines.svh"

module status_capture (
    input  logic                    fifo_wrclk,
    input  logic                    fifo_wrclk_rst_n,
    input  logic                    idi_header_en,
    input  vsb_pkg::datatype_t      idi_datatype,
    input  vsb_pkg::pkt_id_t        idi_wordcount,
    input  logic [`VSB_LC_W-1:0]    idi_linecount,
    input  vsb_pkg::timestamp_t     us_counter_sync,
    vsb_status_if.capture           stat,
    output logic                    overflow
);

    // ======================================================================
    // Header edge detection
    // ======================================================================
    logic                   header_en_d1;
    logic                   header_rise;
    logic                   header_fall;

    always_ff @(posedge fifo_wrclk or negedge fifo_wrclk_rst_n) begin
        if (!fifo_wrclk_rst_n)
            header_en_d1 <= 1'b0;
        else
            header_en_d1 <= idi_header_en;
    end

    assign header_rise =  idi_header_en & ~header_en_d1;
    assign header_fall = ~idi_header_en &  header_en_d1;

    // ======================================================================
    // Field capture at header start
    // ======================================================================
    vsb_pkg::datatype_t     cap_datatype;
    vsb_pkg::pkt_id_t       cap_pkt_id;
    vsb_pkg::timestamp_t    cap_timestamp;
    logic                   is_long;

    assign is_long = (idi_datatype == vsb_pkg::DT_LONG_A) ||
                     (idi_datatype == vsb_pkg::DT_LONG_B);

    always_ff @(posedge fifo_wrclk) begin
        if (header_rise) begin
            cap_datatype  <= idi_datatype;
            cap_pkt_id    <= is_long ? vsb_pkg::pkt_id_t'(idi_linecount)  // Zero-extended
                                     : idi_wordcount;
            cap_timestamp <= us_counter_sync;
        end
    end

    // ======================================================================
    // Pending record and overflow
    // ======================================================================
    always_ff @(posedge fifo_wrclk or negedge fifo_wrclk_rst_n) begin
        if (!fifo_wrclk_rst_n) begin
            stat.pend <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            if (stat.gnt)
                stat.pend <= 1'b0;              // Written into the FIFO
            else if (header_fall && !stat.pend)
                stat.pend <= 1'b1;
            if (header_fall && stat.pend)
                overflow <= 1'b1;               // Sticky until reset
        end
    end

    // Record moves over only when the slot is free
    always_ff @(posedge fifo_wrclk) begin
        if (header_fall && !stat.pend) begin
            stat.datatype  <= cap_datatype;
            stat.pkt_id    <= cap_pkt_id;
            stat.timestamp <= cap_timestamp;
        end
    end

endmodule

/* hdl/sync_bus.sv */
`timescale 1ns/10ps

module sync_bus #(
    parameter int                   BUS_WIDTH = 8,
    parameter logic [BUS_WIDTH-1:0] INI_VALUE = '0
) (
    input  logic                    src_clk,
    input  logic                    src_rst_n,
    input  logic [BUS_WIDTH-1:0]    src_bus,
    input  logic                    dst_clk,
    input  logic                    dst_rst_n,
    output logic [BUS_WIDTH-1:0]    dst_bus
);

    // ======================================================================
    // Source domain
    // ======================================================================
    logic [BUS_WIDTH-1:0]   src_hold;       // Sample in flight
    logic                   src_req;        // Flips once per sample
    logic [1:0]             ack_sync;       // Destination ack into src_clk
    logic                   src_busy;
    logic                   dst_ack;        // Last request toggle consumed
    logic [1:0]             req_sync;       // Request toggle into dst_clk

    assign src_busy = src_req ^ ack_sync[1];   // Waiting for the round trip

    always_ff @(posedge src_clk or negedge src_rst_n) begin
        if (!src_rst_n) begin
            src_req  <= 1'b0;
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], dst_ack};
            if (!src_busy)
                src_req <= ~src_req;            // New sample launched
        end
    end

    // Held steady until the ack returns
    always_ff @(posedge src_clk) begin
        if (!src_busy)
            src_hold <= src_bus;
    end

    // ======================================================================
    // Destination domain
    // ======================================================================
    always_ff @(posedge dst_clk or negedge dst_rst_n) begin
        if (!dst_rst_n) begin
            req_sync <= 2'b00;
            dst_ack  <= 1'b0;
            dst_bus  <= INI_VALUE;
        end else begin
            req_sync <= {req_sync[0], src_req};
            if (req_sync[1] != dst_ack) begin   // Toggle edge seen
                dst_bus <= src_hold;            // Whole word at once
                dst_ack <= req_sync[1];
            end
        end
    end

endmodule

/* hdl/vsb_status_if.sv */
`timescale 1ns/10ps

// Pending record from one capture block to the write arbiter
interface vsb_status_if;

    logic                   pend;       // Record waiting for a FIFO slot
    vsb_pkg::datatype_t     datatype;   // Stable while pend high
    vsb_pkg::pkt_id_t       pkt_id;     // Stable while pend high
    vsb_pkg::timestamp_t    timestamp;  // Stable while pend high
    logic                   gnt;        // One-cycle pulse, written this cycle

    // Capture side owns the record
    modport capture (
        output pend,
        output datatype,
        output pkt_id,
        output timestamp,
        input  gnt
    );

    // Arbiter side owns the grant
    modport arbiter (
        input  pend,
        input  datatype,
        input  pkt_id,
        input  timestamp,
        output gnt
    );

endinterface

/* hdl/vsb_pkg.sv */
`include "vsb_defines.svh"

package vsb_pkg;

    // ======================================================================
    // Record field types
    // ======================================================================
    typedef logic [`VSB_DT_W-1:0]   datatype_t;     // IDI packet datatype
    typedef logic [`VSB_ID_W-1:0]   pkt_id_t;       // Linecount or wordcount
    typedef logic [`VSB_TS_W-1:0]   timestamp_t;    // Synced us counter
    typedef logic [`VSB_CH_W-1:0]   ch_id_t;        // Source channel

    // One FIFO entry, channel on top
    typedef struct packed {
        ch_id_t     ch;
        datatype_t  datatype;
        pkt_id_t    pkt_id;
        timestamp_t timestamp;
    } status_rec_t;

    // ======================================================================
    // Datatype constants
    // ======================================================================
    // Long packets carry the linecount as packet id
    localparam datatype_t DT_LONG_A = 6'h2C;
    localparam datatype_t DT_LONG_B = 6'h2D;

endpackage

/* include/vsb_defines.svh */
`ifndef VSB_DEFINES_SVH
`define VSB_DEFINES_SVH

// ======================================================================
// Channel and FIFO sizing
// ======================================================================
`define VSB_NUM_CH      2       // IDI channels feeding the buffer
`define VSB_FIFO_DEPTH  8       // Status entries, power of two

// ======================================================================
// Record field widths
// ======================================================================
`define VSB_TS_W        80      // Microsecond timestamp
`define VSB_DT_W        6       // IDI datatype
`define VSB_ID_W        16      // Packet id, also the wordcount width
`define VSB_LC_W        3       // IDI linecount
`define VSB_CH_W        1       // Channel number in the record

// Channel, datatype, packet id, timestamp
`define VSB_REC_W       (`VSB_CH_W + `VSB_DT_W + `VSB_ID_W + `VSB_TS_W)

`endif
